/* source/display_pkg.sv */
`default_nettype none

package display_pkg;

    // 720p60 horizontal timing, in pixels
    localparam int H_ACTIVE = 1280;
    localparam int H_FRONT = 110;
    localparam int H_SYNC = 40;
    localparam int H_BACK = 220;
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    // vertical timing, in lines
    localparam int V_ACTIVE = 720;
    localparam int V_FRONT = 5;
    localparam int V_SYNC = 5;
    localparam int V_BACK = 20;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam int H_COUNT_W = 11;
    localparam int V_COUNT_W = 10;

    // quarter-size buffer, upscaled 4x on readout
    localparam int FB_WIDTH = 320;
    localparam int FB_HEIGHT = 180;
    localparam int FB_DEPTH = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDR_W = 16;
    localparam int FB_X_W = 9;
    localparam int FB_Y_W = 8;
    localparam int SCALE_SHIFT = 2;

    // rgb565 in, 8 bits per colour out
    localparam int PIXEL_W = 16;
    localparam int COLOR_W = 8;
    localparam int TMDS_W = 10;

    // count to colour, frame store pipeline depth
    localparam int READ_LATENCY = 3;

    // dvi control symbols, indexed by {c1, c0}
    localparam logic [TMDS_W-1:0] CTRL_00 = 10'b1101010100;
    localparam logic [TMDS_W-1:0] CTRL_01 = 10'b0010101011;
    localparam logic [TMDS_W-1:0] CTRL_10 = 10'b0101010100;
    localparam logic [TMDS_W-1:0] CTRL_11 = 10'b1010101011;

    typedef enum logic [1:0] {
        ACTIVE,
        FRONT_PORCH,
        SYNC,
        BACK_PORCH
    } timing_phase_t;

endpackage

`default_nettype wire

/* source/video_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module video_timing (
    input  wire                                 clk_pixel,
    input  wire                                 arst_n,
    output logic [display_pkg::H_COUNT_W-1:0]   h_count,
    output logic [display_pkg::V_COUNT_W-1:0]   v_count,
    output logic                                hsync_d,
    output logic                                vsync_d,
    output logic                                active_d
);

    // low for the first edge after reset so the counts hold 0 there
    logic                               running;
    logic [display_pkg::H_COUNT_W-1:0]  h_next;
    logic [display_pkg::V_COUNT_W-1:0]  v_next;
    display_pkg::timing_phase_t         h_phase;
    display_pkg::timing_phase_t         v_phase;

    // registered alongside the counts
    logic                               hsync_r;
    logic                               vsync_r;
    logic                               active_r;

    // align with frame store read latency
    logic [display_pkg::READ_LATENCY-1:0] hsync_dly;
    logic [display_pkg::READ_LATENCY-1:0] vsync_dly;
    logic [display_pkg::READ_LATENCY-1:0] active_dly;

    // position within one axis: active, front porch, sync, then back porch
    function automatic display_pkg::timing_phase_t classify(
        input int unsigned pos,
        input int unsigned active,
        input int unsigned front,
        input int unsigned sync
    );
        display_pkg::timing_phase_t phase;
        if (pos < active) begin
            phase = display_pkg::ACTIVE;
        end else if (pos < active + front) begin
            phase = display_pkg::FRONT_PORCH;
        end else if (pos < active + front + sync) begin
            phase = display_pkg::SYNC;
        end else begin
            phase = display_pkg::BACK_PORCH;
        end
        return phase;
    endfunction

    // next position, wraps at line and frame end
    always_comb begin
        h_next = h_count;
        v_next = v_count;
        if (running) begin
            if (h_count == display_pkg::H_TOTAL - 1) begin
                h_next = '0;
                if (v_count == display_pkg::V_TOTAL - 1) begin
                    v_next = '0;
                end else begin
                    v_next = v_count + 1'b1;
                end
            end else begin
                h_next = h_count + 1'b1;
            end
        end
    end

    // classify the upcoming position so flags land with the counts
    always_comb begin
        h_phase = classify(h_next, display_pkg::H_ACTIVE, display_pkg::H_FRONT,
                           display_pkg::H_SYNC);
        v_phase = classify(v_next, display_pkg::V_ACTIVE, display_pkg::V_FRONT,
                           display_pkg::V_SYNC);
    end

    always_ff @(posedge clk_pixel or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
            h_count <= '0;
            v_count <= '0;
            hsync_r <= 1'b0;
            vsync_r <= 1'b0;
            active_r <= 1'b0;
            hsync_dly <= '0;
            vsync_dly <= '0;
            active_dly <= '0;
        end else begin
            running <= 1'b1;
            h_count <= h_next;
            v_count <= v_next;
            // positive sync polarity for 720p
            hsync_r <= (h_phase == display_pkg::SYNC);
            vsync_r <= (v_phase == display_pkg::SYNC);
            active_r <= (h_phase == display_pkg::ACTIVE) && (v_phase == display_pkg::ACTIVE);
            hsync_dly <= {hsync_dly[display_pkg::READ_LATENCY-2:0], hsync_r};
            vsync_dly <= {vsync_dly[display_pkg::READ_LATENCY-2:0], vsync_r};
            active_dly <= {active_dly[display_pkg::READ_LATENCY-2:0], active_r};
        end
    end

    assign hsync_d = hsync_dly[display_pkg::READ_LATENCY-1];
    assign vsync_d = vsync_dly[display_pkg::READ_LATENCY-1];
    assign active_d = active_dly[display_pkg::READ_LATENCY-1];

endmodule

`default_nettype wire

/* source/frame_store.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_store (
    input  wire                                 clk_pixel,
    input  wire                                 arst_n,
    input  wire [display_pkg::H_COUNT_W-1:0]    h_count,
    input  wire [display_pkg::V_COUNT_W-1:0]    v_count,
    input  wire                                 wr_en,
    input  wire [display_pkg::FB_X_W-1:0]       wr_x,
    input  wire [display_pkg::FB_Y_W-1:0]       wr_y,
    input  wire [display_pkg::PIXEL_W-1:0]      wr_pixel,
    output logic [display_pkg::COLOR_W-1:0]     red,
    output logic [display_pkg::COLOR_W-1:0]     green,
    output logic [display_pkg::COLOR_W-1:0]     blue
);

    // one rgb565 word per buffer pixel
    logic [display_pkg::PIXEL_W-1:0]    pixel_mem [0:display_pkg::FB_DEPTH-1];

    logic [display_pkg::FB_ADDR_W-1:0]  wr_addr;
    logic [display_pkg::FB_X_W-1:0]     rd_x;
    logic [display_pkg::FB_Y_W-1:0]     rd_y;
    logic                               in_frame;
    logic [display_pkg::FB_ADDR_W-1:0]  rd_addr_next;

    // stage 1 read address, stage 2 array word
    logic [display_pkg::FB_ADDR_W-1:0]  rd_addr;
    logic [display_pkg::PIXEL_W-1:0]    pix_q;
    logic                               addr_valid;
    logic                               pix_valid;

    // row major, row times buffer width plus column
    assign wr_addr = display_pkg::FB_ADDR_W'(wr_y) *
                     display_pkg::FB_ADDR_W'(display_pkg::FB_WIDTH) +
                     display_pkg::FB_ADDR_W'(wr_x);

    // nearest neighbour, drop the low count bits
    assign rd_x = h_count[display_pkg::H_COUNT_W-1:display_pkg::SCALE_SHIFT];
    assign rd_y = v_count[display_pkg::V_COUNT_W-1:display_pkg::SCALE_SHIFT];
    assign in_frame = (h_count < display_pkg::H_ACTIVE) && (v_count < display_pkg::V_ACTIVE);

    // park the address at 0 in blanking, keeps reads inside the array
    assign rd_addr_next = in_frame ?
        display_pkg::FB_ADDR_W'(rd_y) * display_pkg::FB_ADDR_W'(display_pkg::FB_WIDTH) +
        display_pkg::FB_ADDR_W'(rd_x) : '0;

    // write port
    always_ff @(posedge clk_pixel) begin
        if (wr_en) begin
            pixel_mem[wr_addr] <= wr_pixel;
        end
    end

    // read pipeline data path
    always_ff @(posedge clk_pixel) begin
        rd_addr <= rd_addr_next;
        pix_q <= pixel_mem[rd_addr];
        // rgb565 to 888 by zero fill, black outside the picture
        red <= pix_valid ? {pix_q[15:11], 3'b000} : '0;
        green <= pix_valid ? {pix_q[10:5], 2'b00} : '0;
        blue <= pix_valid ? {pix_q[4:0], 3'b000} : '0;
    end

    // in-frame flag follows the address down the pipe
    always_ff @(posedge clk_pixel or negedge arst_n) begin
        if (!arst_n) begin
            addr_valid <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            addr_valid <= in_frame;
            pix_valid <= addr_valid;
        end
    end

endmodule

`default_nettype wire

/* source/tmds_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module tmds_encoder (
    input  wire                                 clk_pixel,
    input  wire                                 arst_n,
    input  wire [display_pkg::COLOR_W-1:0]      video_data,
    input  wire [1:0]                           control,
    input  wire                                 video_enable,
    output logic [display_pkg::TMDS_W-1:0]      tmds
);

    // stage 1 transition minimised word, bit 8 set for xor
    logic [8:0]         q_m;
    logic [3:0]         data_ones;
    logic               use_xnor;

    // balance of q_m[7:0], ones minus zeros
    logic [3:0]         q_ones;
    logic [3:0]         q_zeros;
    logic signed [4:0]  q_diff;

    // running disparity, ones minus zeros sent so far
    logic signed [4:0]  disparity;
    logic signed [4:0]  disparity_next;
    logic [display_pkg::TMDS_W-1:0] symbol;

    function automatic logic [3:0] count_ones(input logic [7:0] bits);
        logic [3:0] total;
        total = '0;
        for (int i = 0; i < 8; i++) begin
            total = total + {3'b000, bits[i]};
        end
        return total;
    endfunction

    always_comb begin
        data_ones = count_ones(video_data);
        // xnor when the byte is ones-heavy, ties broken by bit 0
        use_xnor = (data_ones > 4'd4) || ((data_ones == 4'd4) && !video_data[0]);
        q_m[0] = video_data[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ video_data[i]) : (q_m[i-1] ^ video_data[i]);
        end
        q_m[8] = !use_xnor;
        q_ones = count_ones(q_m[7:0]);
        q_zeros = 4'd8 - q_ones;
        q_diff = $signed({1'b0, q_ones}) - $signed({1'b0, q_zeros});
    end

    // dc balance, invert the payload when it would grow the disparity
    always_comb begin
        if ((disparity == 5'sd0) || (q_ones == q_zeros)) begin
            symbol = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            disparity_next = q_m[8] ? disparity + q_diff : disparity - q_diff;
        end else if (((disparity > 5'sd0) && (q_ones > q_zeros)) ||
                     ((disparity < 5'sd0) && (q_zeros > q_ones))) begin
            symbol = {1'b1, q_m[8], ~q_m[7:0]};
            disparity_next = disparity + (q_m[8] ? 5'sd2 : 5'sd0) - q_diff;
        end else begin
            symbol = {1'b0, q_m[8], q_m[7:0]};
            disparity_next = disparity - (q_m[8] ? 5'sd0 : 5'sd2) + q_diff;
        end
    end

    always_ff @(posedge clk_pixel or negedge arst_n) begin
        if (!arst_n) begin
            tmds <= display_pkg::CTRL_00;
            disparity <= '0;
        end else if (video_enable) begin
            tmds <= symbol;
            disparity <= disparity_next;
        end else begin
            // blanking sends a control symbol and restarts the balance
            disparity <= '0;
            case (control)
                2'b00: tmds <= display_pkg::CTRL_00;
                2'b01: tmds <= display_pkg::CTRL_01;
                2'b10: tmds <= display_pkg::CTRL_10;
                default: tmds <= display_pkg::CTRL_11;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module display_top (
    input  wire                                 clk_pixel,
    input  wire                                 arst_n,
    input  wire                                 wr_en,
    input  wire [display_pkg::FB_X_W-1:0]       wr_x,
    input  wire [display_pkg::FB_Y_W-1:0]       wr_y,
    input  wire [display_pkg::PIXEL_W-1:0]      wr_pixel,
    output logic [display_pkg::TMDS_W-1:0]      tmds_red,
    output logic [display_pkg::TMDS_W-1:0]      tmds_green,
    output logic [display_pkg::TMDS_W-1:0]      tmds_blue
);

    // raw position, read side of the buffer
    logic [display_pkg::H_COUNT_W-1:0]  h_count;
    logic [display_pkg::V_COUNT_W-1:0]  v_count;

    // control, already aligned with the colours
    logic                               hsync_d;
    logic                               vsync_d;
    logic                               active_d;

    logic [display_pkg::COLOR_W-1:0]    red;
    logic [display_pkg::COLOR_W-1:0]    green;
    logic [display_pkg::COLOR_W-1:0]    blue;

    video_timing timing0 (
        .clk_pixel  (clk_pixel),
        .arst_n     (arst_n),
        .h_count    (h_count),
        .v_count    (v_count),
        .hsync_d    (hsync_d),
        .vsync_d    (vsync_d),
        .active_d   (active_d)
    );

    frame_store store0 (
        .clk_pixel  (clk_pixel),
        .arst_n     (arst_n),
        .h_count    (h_count),
        .v_count    (v_count),
        .wr_en      (wr_en),
        .wr_x       (wr_x),
        .wr_y       (wr_y),
        .wr_pixel   (wr_pixel),
        .red        (red),
        .green      (green),
        .blue       (blue)
    );

    // red and green carry no control
    tmds_encoder enc_red (
        .clk_pixel      (clk_pixel),
        .arst_n         (arst_n),
        .video_data     (red),
        .control        (2'b00),
        .video_enable   (active_d),
        .tmds           (tmds_red)
    );

    tmds_encoder enc_green (
        .clk_pixel      (clk_pixel),
        .arst_n         (arst_n),
        .video_data     (green),
        .control        (2'b00),
        .video_enable   (active_d),
        .tmds           (tmds_green)
    );

    // blue carries c1 = vsync, c0 = hsync
    tmds_encoder enc_blue (
        .clk_pixel      (clk_pixel),
        .arst_n         (arst_n),
        .video_data     (blue),
        .control        ({vsync_d, hsync_d}),
        .video_enable   (active_d),
        .tmds           (tmds_blue)
    );

endmodule

`default_nettype wire

/* dv/display_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module display_assert #(
    parameter bit CHECK_ENCODER = 1'b1
) (
    input  wire                                 clk_pixel,
    input  wire                                 arst_n,
    input  wire signed [4:0]                    disparity,
    input  wire [display_pkg::TMDS_W-1:0]       tmds,
    input  wire                                 video_enable,
    input  wire [display_pkg::H_COUNT_W-1:0]    h_count
);

    generate
        if (CHECK_ENCODER) begin : g_encoder
            // dvi balancing keeps the running count inside +-8
            disparity_bound: assert property (@(posedge clk_pixel) disable iff (!arst_n)
                (disparity >= -5'sd8) && (disparity <= 5'sd8))
                else $error("encoder running disparity left the +-8 band");

            // blanking goes out as one of the four control words on the next cycle
            control_in_blanking: assert property (@(posedge clk_pixel) disable iff (!arst_n)
                !video_enable |=> (tmds == display_pkg::CTRL_00) ||
                                  (tmds == display_pkg::CTRL_01) ||
                                  (tmds == display_pkg::CTRL_10) ||
                                  (tmds == display_pkg::CTRL_11))
                else $error("non-control symbol sent during blanking");
        end else begin : g_timing
            // pixel counter wraps before the line total
            h_count_range: assert property (@(posedge clk_pixel) disable iff (!arst_n)
                h_count < display_pkg::H_TOTAL)
                else $error("h_count reached the line total");
        end
    endgenerate

endmodule

// encoder instances check balance and blanking symbols
bind tmds_encoder display_assert #(.CHECK_ENCODER(1'b1)) enc_checks (
    .clk_pixel      (clk_pixel),
    .arst_n         (arst_n),
    .disparity      (disparity),
    .tmds           (tmds),
    .video_enable   (video_enable),
    .h_count        (11'd0)
);

// timing instance checks the pixel counter
bind video_timing display_assert #(.CHECK_ENCODER(1'b0)) timing_checks (
    .clk_pixel      (clk_pixel),
    .arst_n         (arst_n),
    .disparity      (5'sd0),
    .tmds           (display_pkg::CTRL_00),
    .video_enable   (1'b0),
    .h_count        (h_count)
);

`default_nettype wire

/* dv/display_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module display_tb;

    localparam int FRAME_CYCLES = display_pkg::H_TOTAL * display_pkg::V_TOTAL;
    localparam int TIMEOUT_CYCLES = 2 * FRAME_CYCLES + 2000;
    // symbol for position p is out after edge p + 4
    localparam int PIPE_DEPTH = 4;
    localparam int N_ENTRIES = 8;
    localparam int N_WRITES = display_pkg::FB_DEPTH + N_ENTRIES;
    localparam logic [31:0] LFSR_SEED = 32'h9bc7_de33;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam int HS_START = display_pkg::H_ACTIVE + display_pkg::H_FRONT;
    localparam int VS_START = display_pkg::V_ACTIVE + display_pkg::V_FRONT;

    logic                               clk_pixel;
    logic                               arst_n;
    logic                               wr_en;
    logic [display_pkg::FB_X_W-1:0]     wr_x;
    logic [display_pkg::FB_Y_W-1:0]     wr_y;
    logic [display_pkg::PIXEL_W-1:0]    wr_pixel;
    logic [display_pkg::TMDS_W-1:0]     tmds_red;
    logic [display_pkg::TMDS_W-1:0]     tmds_green;
    logic [display_pkg::TMDS_W-1:0]     tmds_blue;

    // stimulus table of buffer x and y, written pixel and the pixel kept after all writes
    int                                 tbl_x [N_ENTRIES];
    int                                 tbl_y [N_ENTRIES];
    logic [15:0]                        tbl_pix [N_ENTRIES];
    logic [15:0]                        tbl_exp [N_ENTRIES];

    // what the buffer should hold
    logic [15:0]                        shadow [display_pkg::FB_DEPTH];
    logic [31:0]                        lfsr;
    int                                 cycle_count;
    // ones minus zeros per channel since line start
    int                                 bal_r;
    int                                 bal_g;
    int                                 bal_b;

    display_top dut0 (
        .clk_pixel  (clk_pixel),
        .arst_n     (arst_n),
        .wr_en      (wr_en),
        .wr_x       (wr_x),
        .wr_y       (wr_y),
        .wr_pixel   (wr_pixel),
        .tmds_red   (tmds_red),
        .tmds_green (tmds_green),
        .tmds_blue  (tmds_blue)
    );

    initial begin
        clk_pixel = 1'b0;
        forever #4 clk_pixel = ~clk_pixel;
    end

    // galois form shifting right and folding in the taps on a one out
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    // odd multiplier gives every address its own word
    function automatic logic [15:0] fill_pattern(input int addr);
        logic [31:0] prod;
        prod = 32'(addr) * 32'd40503;
        return prod[15:0];
    endfunction

    // undo the inversion and then the xor or xnor chain
    function automatic logic [7:0] decode_symbol(input logic [9:0] sym);
        logic [7:0] q;
        logic [7:0] d;
        q = sym[9] ? ~sym[7:0] : sym[7:0];
        d[0] = q[0];
        for (int i = 1; i < 8; i++) begin
            d[i] = sym[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
        end
        return d;
    endfunction

    function automatic int ones_minus_zeros(input logic [9:0] sym);
        int ones;
        ones = 0;
        for (int i = 0; i < 10; i++) begin
            ones = ones + int'(sym[i]);
        end
        return 2 * ones - 10;
    endfunction

    // c1 is vsync and c0 is hsync
    function automatic logic [9:0] ctrl_symbol(input logic vs, input logic hs);
        case ({vs, hs})
            2'b00: return display_pkg::CTRL_00;
            2'b01: return display_pkg::CTRL_01;
            2'b10: return display_pkg::CTRL_10;
            default: return display_pkg::CTRL_11;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    // one lfsr step per pixel bit
    task automatic draw_pixel(output logic [15:0] pix);
        for (int b = 0; b < 16; b++) begin
            lfsr = lfsr_step(lfsr);
            pix[b] = lfsr[0];
        end
    endtask

    task automatic build_table();
        // four corners and two inner points plus a repeat of entry 4 and one near the top
        tbl_x = '{0, 319, 0, 319, 100, 211, 100, 57};
        tbl_y = '{0, 0, 179, 179, 50, 133, 50, 3};
        for (int i = 0; i < N_ENTRIES; i++) begin
            draw_pixel(tbl_pix[i]);
        end
        // later writes to the same address win
        for (int i = 0; i < N_ENTRIES; i++) begin
            tbl_exp[i] = tbl_pix[i];
            for (int j = i + 1; j < N_ENTRIES; j++) begin
                if (tbl_x[j] == tbl_x[i] && tbl_y[j] == tbl_y[i]) begin
                    tbl_exp[i] = tbl_pix[j];
                end
            end
        end
    endtask

    // whole-buffer fill first and the table entries after it
    task automatic drive_write(input int n);
        int idx;
        int addr;
        if (n < display_pkg::FB_DEPTH) begin
            addr = n;
            wr_x = display_pkg::FB_X_W'(n % display_pkg::FB_WIDTH);
            wr_y = display_pkg::FB_Y_W'(n / display_pkg::FB_WIDTH);
            wr_pixel = fill_pattern(n);
        end else if (n < N_WRITES) begin
            idx = n - display_pkg::FB_DEPTH;
            addr = tbl_y[idx] * display_pkg::FB_WIDTH + tbl_x[idx];
            wr_x = display_pkg::FB_X_W'(tbl_x[idx]);
            wr_y = display_pkg::FB_Y_W'(tbl_y[idx]);
            wr_pixel = tbl_pix[idx];
        end else begin
            wr_en = 1'b0;
            return;
        end
        wr_en = 1'b1;
        shadow[addr] = wr_pixel;
    endtask

    // compare the three symbols for screen position p
    task automatic check_symbols(input int p);
        int h;
        int v;
        int bx;
        int by;
        logic [15:0] pix;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic hs;
        logic vs;
        if (p < 0) begin
            check("tmds_red", 32'(tmds_red), 32'(display_pkg::CTRL_00));
            check("tmds_green", 32'(tmds_green), 32'(display_pkg::CTRL_00));
            check("tmds_blue", 32'(tmds_blue), 32'(display_pkg::CTRL_00));
            return;
        end
        h = p % display_pkg::H_TOTAL;
        v = (p / display_pkg::H_TOTAL) % display_pkg::V_TOTAL;
        if (h >= display_pkg::H_ACTIVE || v >= display_pkg::V_ACTIVE) begin
            hs = (h >= HS_START) && (h < HS_START + display_pkg::H_SYNC);
            vs = (v >= VS_START) && (v < VS_START + display_pkg::V_SYNC);
            check("tmds_red", 32'(tmds_red), 32'(display_pkg::CTRL_00));
            check("tmds_green", 32'(tmds_green), 32'(display_pkg::CTRL_00));
            check("tmds_blue", 32'(tmds_blue), 32'(ctrl_symbol(vs, hs)));
            return;
        end
        // picture checks in frame 1 only since frame 0 is still being written
        if (p / FRAME_CYCLES != 1) begin
            return;
        end
        if (h == 0) begin
            bal_r = 0;
            bal_g = 0;
            bal_b = 0;
        end
        bx = h >> display_pkg::SCALE_SHIFT;
        by = v >> display_pkg::SCALE_SHIFT;
        pix = shadow[by * display_pkg::FB_WIDTH + bx];
        r = decode_symbol(tmds_red);
        g = decode_symbol(tmds_green);
        b = decode_symbol(tmds_blue);
        // rgb565 widened with zero low bits
        check("tmds_red colour", 32'(r), 32'({pix[15:11], 3'b000}));
        check("tmds_green colour", 32'(g), 32'({pix[10:5], 2'b00}));
        check("tmds_blue colour", 32'(b), 32'({pix[4:0], 3'b000}));
        for (int i = 0; i < N_ENTRIES; i++) begin
            if (bx == tbl_x[i] && by == tbl_y[i]) begin
                check("tmds_red table colour", 32'(r), 32'({tbl_exp[i][15:11], 3'b000}));
                check("tmds_green table colour", 32'(g), 32'({tbl_exp[i][10:5], 2'b00}));
                check("tmds_blue table colour", 32'(b), 32'({tbl_exp[i][4:0], 3'b000}));
            end
        end
        // dc balance seen on the wire
        bal_r += ones_minus_zeros(tmds_red);
        bal_g += ones_minus_zeros(tmds_green);
        bal_b += ones_minus_zeros(tmds_blue);
        check("tmds_red balance within 10", 32'(bal_r >= -10 && bal_r <= 10), 32'd1);
        check("tmds_green balance within 10", 32'(bal_g >= -10 && bal_g <= 10), 32'd1);
        check("tmds_blue balance within 10", 32'(bal_b >= -10 && bal_b <= 10), 32'd1);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_pixel);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $fatal(1, "timeout");
    end

    initial begin
        arst_n = 1'b0;
        wr_en = 1'b0;
        wr_x = '0;
        wr_y = '0;
        wr_pixel = '0;
        bal_r = 0;
        bal_g = 0;
        bal_b = 0;
        lfsr = LFSR_SEED;
        build_table();
        repeat (8) @(posedge clk_pixel);
        #1;
        // reset value on all channels
        check_symbols(-1);
        arst_n = 1'b1;
        // e counts edges from the first one after reset release
        for (int e = 0; e < 2 * FRAME_CYCLES + PIPE_DEPTH; e++) begin
            @(posedge clk_pixel);
            #1;
            drive_write(e);
            check_symbols(e - PIPE_DEPTH);
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
source/display_pkg.sv
source/video_timing.sv
source/frame_store.sv
source/tmds_encoder.sv
source/display_top.sv
dv/display_assert.sv
dv/display_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= display_tb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= Test completed successfully
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	rm -f $(LOG)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
